// ==== fp_consts.svh ====
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// Field widths of one floating-point word
// Set 11 and 52 here for a double-precision build
`define FP_EXP_BITS 8
`define FP_MAN_BITS 23

// Exponent bias, 2**(FP_EXP_BITS-1) - 1
`define FP_BIAS 127

// Width of the request tag carried alongside each operation
`define FP_TAG_BITS 4

// Request strobe to response strobe, in clock cycles
`define FP_LATENCY 2

// Normalization shift count, wide enough to hold the full raw sum width
`define FP_SHIFT_BITS ($clog2(`FP_MAN_BITS + 6))

// Mantissa of the canonical quiet NaN
`define FP_QNAN_MAN ({1'b1, {(`FP_MAN_BITS-1){1'b0}}})

`endif

// ==== fp_pkg.sv ====
`default_nettype none
`include "fp_consts.svh"

package fp_pkg;

  // One IEEE-754 word, fields in bit order from the top
  typedef struct packed {
    logic                    sign;
    logic [`FP_EXP_BITS-1:0] exp;
    logic [`FP_MAN_BITS-1:0] man;
  } fp_word_t;

  typedef enum logic {
    FP_ADD = 1'b0,
    FP_SUB = 1'b1
  } fp_op_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
  } fp_flags_t;

  typedef struct packed {
    fp_op_e                  op;
    fp_word_t                a;
    fp_word_t                b;
    logic [`FP_TAG_BITS-1:0] tag;
  } fp_req_t;

  typedef struct packed {
    fp_word_t                result;
    fp_flags_t               flags;
    logic [`FP_TAG_BITS-1:0] tag;
  } fp_rsp_t;

  // Aligner output, the small significand carries guard, round and sticky below it
  typedef struct packed {
    logic [`FP_EXP_BITS:0]   exp;
    logic [`FP_MAN_BITS:0]   big_sig;
    logic [`FP_MAN_BITS+3:0] small_sig;
    logic                    eff_sub;
    logic                    sign;
  } fp_aligned_t;

endpackage

`default_nettype wire

// ==== fp_lead_zero.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fp_consts.svh"

// Leading-one detector for the raw significand sum
// Bit layout of sum, top down: carry, hidden, mantissa, guard, round, sticky
module fp_lead_zero (
  input  logic [`FP_MAN_BITS+4:0]   sum,
  output logic [`FP_SHIFT_BITS-1:0] shift
);

  localparam int SUM_W = `FP_MAN_BITS + 5;
  localparam int HID   = SUM_W - 2;
  localparam int SB    = `FP_SHIFT_BITS;

  logic found;

  always_comb begin
    // All-zero sum reports the full width
    shift = SB'(SUM_W);
    found = 1'b0;
    // Scan from the top, the first one seen sets the count
    for (int i = SUM_W - 1; i >= 0; i--) begin
      if (!found && sum[i]) begin
        found = 1'b1;
        // A carry-position one needs no left shift
        if (i == SUM_W - 1) begin
          shift = '0;
        end else begin
          shift = SB'(HID - i);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== fp_align.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fp_consts.svh"

// Operand unpack and alignment
// b arrives with its sign already flipped for a subtract
module fp_align import fp_pkg::*; (
  input  fp_word_t    a,
  input  fp_word_t    b,
  output fp_aligned_t aligned
);

  localparam int EXP_W  = `FP_EXP_BITS;
  localparam int SIG_W  = `FP_MAN_BITS + 1;
  localparam int SAT    = SIG_W + 2;
  localparam int WIDE_W = 2 * SIG_W + 2;

  logic              a_zero;
  logic              b_zero;
  logic [SIG_W-1:0]  sig_a;
  logic [SIG_W-1:0]  sig_b;
  logic              a_big;
  fp_word_t          big;
  logic [SIG_W-1:0]  big_sig;
  logic [SIG_W-1:0]  small_sig;
  logic [EXP_W-1:0]  small_exp;
  logic [EXP_W-1:0]  diff;
  logic [EXP_W-1:0]  sat_diff;
  logic [WIDE_W-1:0] wide;

  // Exponent zero means zero, subnormal mantissas are dropped
  assign a_zero = (a.exp == '0);
  assign b_zero = (b.exp == '0);
  assign sig_a  = a_zero ? '0 : {1'b1, a.man};
  assign sig_b  = b_zero ? '0 : {1'b1, b.man};

  // Magnitude order, exponent first, then significand
  assign a_big = (a.exp > b.exp) || ((a.exp == b.exp) && (sig_a >= sig_b));

  assign big       = a_big ? a : b;
  assign big_sig   = a_big ? sig_a : sig_b;
  assign small_sig = a_big ? sig_b : sig_a;
  assign small_exp = a_big ? b.exp : a.exp;

  assign diff = big.exp - small_exp;

  // Past SAT places every bit of the small operand lands in sticky
  assign sat_diff = (diff > EXP_W'(SAT)) ? EXP_W'(SAT) : diff;

  // Shift into a double-width window, the lower half feeds sticky
  assign wide = {small_sig, {(SIG_W + 2){1'b0}}} >> sat_diff;

  assign aligned.exp       = {1'b0, big.exp};
  assign aligned.big_sig   = big_sig;
  assign aligned.small_sig = {wide[WIDE_W-1:SIG_W], |wide[SIG_W-1:0]};
  assign aligned.eff_sub   = a.sign ^ b.sign;
  assign aligned.sign      = big.sign;

endmodule

`default_nettype wire

// ==== fp_adder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fp_consts.svh"

// Combinational add/subtract core
// Align, add, normalize, round to nearest even, then special cases
module fp_adder import fp_pkg::*; (
  input  fp_op_e    op,
  input  fp_word_t  a,
  input  fp_word_t  b,
  output fp_word_t  result,
  output fp_flags_t flags
);

  localparam int MAN_W    = `FP_MAN_BITS;
  localparam int EXP_W    = `FP_EXP_BITS;
  localparam int SIG_W    = MAN_W + 1;
  localparam int SUM_W    = MAN_W + 5;
  localparam int NORM_W   = SUM_W - 1;
  localparam int RND_W    = SIG_W + 1;
  localparam int EW       = EXP_W + 2;
  localparam int SB       = `FP_SHIFT_BITS;
  localparam int EXP_ONES = (1 << EXP_W) - 1;

  fp_word_t          b_eff;
  fp_aligned_t       al;
  logic [SUM_W-1:0]  big_ext;
  logic [SUM_W-1:0]  small_ext;
  logic [SUM_W-1:0]  raw;
  logic [SB-1:0]     lz;
  logic [NORM_W-1:0] norm;
  logic [EW-1:0]     exp_n;
  logic [EW-1:0]     exp_r;
  logic              grs;
  logic              round_up;
  logic [RND_W-1:0]  rounded;
  logic              rnd_carry;
  logic [MAN_W-1:0]  man_r;
  logic              a_nan;
  logic              b_nan;
  logic              a_inf;
  logic              b_inf;
  logic              invalid;
  logic              inf_in;
  logic              ovf;
  logic              unf;
  logic              exact_zero;

  // Subtract is add with b negated
  always_comb begin
    b_eff      = b;
    b_eff.sign = b.sign ^ (op == FP_SUB);
  end

  fp_align u_align (
    .a       (a),
    .b       (b_eff),
    .aligned (al)
  );

  // Big operand gets zero guard, round and sticky
  assign big_ext   = {1'b0, al.big_sig, 3'b000};
  assign small_ext = {1'b0, al.small_sig};
  assign raw       = al.eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);

  fp_lead_zero u_lead_zero (
    .sum   (raw),
    .shift (lz)
  );

  always_comb begin
    if (raw[SUM_W-1]) begin
      // Add carry, one place right with the lost bit folded into sticky
      norm  = {raw[SUM_W-1:2], raw[1] | raw[0]};
      exp_n = EW'(al.exp) + EW'(1);
    end else if (al.eff_sub) begin
      norm  = NORM_W'(raw << lz);
      exp_n = EW'(al.exp) - EW'(lz);
    end else begin
      norm  = raw[NORM_W-1:0];
      exp_n = EW'(al.exp);
    end
  end

  // norm[3] is the result LSB, below it guard, round, sticky
  assign grs      = |norm[2:0];
  assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
  assign rounded  = {1'b0, norm[NORM_W-1:3]} + RND_W'(round_up);

  // Rounding carry leaves 10...0, renormalize by one
  assign rnd_carry = rounded[SIG_W];
  assign man_r     = rnd_carry ? rounded[SIG_W-1:1] : rounded[MAN_W-1:0];
  assign exp_r     = exp_n + EW'(rnd_carry);

  // Top bit of exp_r marks a negative exponent
  assign unf = exp_r[EW-1] || (exp_r == '0);
  assign ovf = !exp_r[EW-1] && (exp_r >= EW'(EXP_ONES));

  assign a_nan = (a.exp == '1) && (a.man != '0);
  assign b_nan = (b_eff.exp == '1) && (b_eff.man != '0);
  assign a_inf = (a.exp == '1) && (a.man == '0);
  assign b_inf = (b_eff.exp == '1) && (b_eff.man == '0);

  // Opposite infinities have no defined sum
  assign invalid    = a_nan | b_nan | (a_inf & b_inf & (a.sign ^ b_eff.sign));
  assign inf_in     = a_inf | b_inf;
  assign exact_zero = (raw == '0);

  always_comb begin
    flags         = '0;
    flags.inexact = grs & ~invalid & ~inf_in;
    result        = '{sign: al.sign, exp: exp_r[EXP_W-1:0], man: man_r};
    if (invalid) begin
      result        = '{sign: 1'b0, exp: '1, man: `FP_QNAN_MAN};
      flags.invalid = 1'b1;
    end else if (inf_in) begin
      result = '{sign: (a_inf ? a.sign : b_eff.sign), exp: '1, man: '0};
    end else if (ovf) begin
      result         = '{sign: al.sign, exp: '1, man: '0};
      flags.overflow = 1'b1;
    end else if (exact_zero) begin
      // Cancellation gives +0, only two negative zeros keep the sign
      result = '{sign: al.sign & ~al.eff_sub, exp: '0, man: '0};
    end else if (unf) begin
      result = '{sign: al.sign, exp: '0, man: '0};
    end
  end

endmodule

`default_nettype wire

// ==== fp_add_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fp_consts.svh"

// Pipelined floating-point add/subtract unit
// Input register, combinational adder, output register
module fp_add_unit import fp_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    req_valid,
  input  fp_req_t req,
  output logic    rsp_valid,
  output fp_rsp_t rsp
);

  logic      s1_valid;
  fp_req_t   s1_req;
  fp_word_t  sum;
  fp_flags_t sum_flags;

  // Stage one, request capture
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      s1_req <= req;
    end
  end

  fp_adder u_adder (
    .op     (s1_req.op),
    .a      (s1_req.a),
    .b      (s1_req.b),
    .result (sum),
    .flags  (sum_flags)
  );

  // Stage two, result with its tag
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      rsp <= '{result: sum, flags: sum_flags, tag: s1_req.tag};
    end
  end

  // Every strobe answers after a fixed latency, and nothing else does
  a_latency_fwd: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> ##`FP_LATENCY rsp_valid);

  a_latency_back: assert property (@(posedge clk) disable iff (reset)
    rsp_valid |-> $past(req_valid, `FP_LATENCY));

  // Invalid always comes with the canonical quiet NaN
  a_invalid_nan: assert property (@(posedge clk) disable iff (reset)
    (rsp_valid && rsp.flags.invalid) |->
      (!rsp.result.sign && (rsp.result.exp == '1) && (rsp.result.man == `FP_QNAN_MAN)));

  a_overflow_inf: assert property (@(posedge clk) disable iff (reset)
    (rsp_valid && rsp.flags.overflow) |->
      ((rsp.result.exp == '1) && (rsp.result.man == '0)));

endmodule

`default_nettype wire

// ==== fp_ref_model.svh ====
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Wide enough for the largest normal significand at the top exponent, plus a carry
typedef logic [(1 << `FP_EXP_BITS) + `FP_MAN_BITS + 1:0] wide_t;

function automatic logic nan_code(input fp_word_t w);
  return (w.exp == '1) && (w.man != '0);
endfunction

function automatic logic infinite(input fp_word_t w);
  return (w.exp == '1) && (w.man == '0);
endfunction

// Value in units of the LSB at the smallest normal exponent
// Subnormals count as zero
function automatic wide_t scaled_magnitude(input fp_word_t w);
  wide_t sig;
  if (w.exp == '0) begin
    return '0;
  end
  sig = wide_t'({1'b1, w.man});
  return sig << (w.exp - 1);
endfunction

// Expected response for one request, from the exact sum
function automatic fp_rsp_t expected_rsp(input fp_req_t rq);
  fp_word_t a;
  fp_word_t b;
  wide_t    va;
  wide_t    vb;
  wide_t    mag;
  wide_t    kept;
  wide_t    rem;
  wide_t    half;
  logic     sign;
  logic     up;
  int       top;
  int       sh;
  int       e;
  fp_rsp_t  r;
  a      = rq.a;
  b      = rq.b;
  b.sign = rq.b.sign ^ (rq.op == FP_SUB);
  r      = '0;
  r.tag  = rq.tag;
  if (nan_code(a) || nan_code(b) || (infinite(a) && infinite(b) && (a.sign != b.sign))) begin
    r.result        = '{sign: 1'b0, exp: '1, man: {1'b1, {(`FP_MAN_BITS-1){1'b0}}}};
    r.flags.invalid = 1'b1;
    return r;
  end
  if (infinite(a) || infinite(b)) begin
    r.result.sign = infinite(a) ? a.sign : b.sign;
    r.result.exp  = '1;
    return r;
  end
  va = scaled_magnitude(a);
  vb = scaled_magnitude(b);
  if (a.sign == b.sign) begin
    mag  = va + vb;
    sign = a.sign;
  end else if (va >= vb) begin
    mag  = va - vb;
    sign = a.sign;
  end else begin
    mag  = vb - va;
    sign = b.sign;
  end
  // Only two negative zeros give -0
  if (mag == '0) begin
    r.result.sign = a.sign & b.sign;
    return r;
  end
  top = 0;
  for (int i = 0; i < $bits(wide_t); i++) begin
    if (mag[i]) begin
      top = i;
    end
  end
  e  = top - `FP_MAN_BITS + 1;
  sh = (top > `FP_MAN_BITS) ? top - `FP_MAN_BITS : 0;
  kept = mag >> sh;
  rem  = mag & ((wide_t'(1) << sh) - wide_t'(1));
  half = (sh > 0) ? (wide_t'(1) << (sh - 1)) : '0;
  // Nearest, ties to the even significand
  up   = (sh > 0) && ((rem > half) || ((rem == half) && kept[0]));
  kept = kept + wide_t'(up);
  r.flags.inexact = (rem != '0);
  if (kept[`FP_MAN_BITS + 1]) begin
    kept = kept >> 1;
    e    = e + 1;
  end
  r.result.sign = sign;
  if (e >= (1 << `FP_EXP_BITS) - 1) begin
    r.result.exp     = '1;
    r.flags.overflow = 1'b1;
  end else if (e > 0) begin
    r.result.exp = e[`FP_EXP_BITS-1:0];
    r.result.man = kept[`FP_MAN_BITS-1:0];
  end
  return r;
endfunction

`endif

// ==== tb_fp_add_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fp_consts.svh"

module tb_fp_add_unit
  import fp_pkg::*;
();

  localparam int RANDOM_COUNT = 2000;
  // 2000 random requests at up to two cycles each, directed tests and reset
  localparam int MAX_CYCLES   = 6000;

  logic    clk;
  logic    reset;
  logic    req_valid;
  fp_req_t req;
  logic    rsp_valid;
  fp_rsp_t rsp;

  int                      seed;
  int                      errors;
  int                      checks;
  int                      cycles = 0;
  logic [`FP_TAG_BITS-1:0] next_tag;
  fp_rsp_t                 exp_q[$];
  int                      edge_q[$];

  `include "fp_ref_model.svh"

  fp_add_unit UUT (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses outstanding", cycles, exp_q.size());
      $display("Something failed");
      $finish;
    end
  end

  // Random normal word, exponent within spread of center
  function automatic fp_word_t random_normal(input int center, input int spread);
    fp_word_t w;
    int       e;
    w = fp_word_t'($random(seed));
    e = center + ($random(seed) % (spread + 1));
    if (e < 1) begin
      e = 1;
    end
    if (e > (1 << `FP_EXP_BITS) - 2) begin
      e = (1 << `FP_EXP_BITS) - 2;
    end
    w.exp = e[`FP_EXP_BITS-1:0];
    return w;
  endfunction

  // One strobe, held for a single cycle, expected response queued
  task automatic issue_request(input fp_op_e op, input fp_word_t a, input fp_word_t b);
    fp_req_t r;
    r.op     = op;
    r.a      = a;
    r.b      = b;
    r.tag    = next_tag;
    next_tag = next_tag + 1'b1;
    @(posedge clk);
    #0.5;
    req_valid = 1'b1;
    req       = r;
    exp_q.push_back(expected_rsp(r));
    // Edge that the strobe follows
    edge_q.push_back(cycles);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #0.5;
      req_valid = 1'b0;
    end
  endtask

  // Responses are stable between edges
  always @(negedge clk) begin
    fp_rsp_t want;
    int      issued;
    if (!reset && rsp_valid !== 1'b0) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t with no request outstanding", $time);
        errors++;
      end else begin
        want   = exp_q.pop_front();
        issued = edge_q.pop_front();
        checks++;
        if (rsp.result !== want.result) begin
          $display("** Error at %0t: rsp.result = %h, expected %h (tag %0d)",
                   $time, rsp.result, want.result, want.tag);
          errors++;
        end
        if (rsp.flags !== want.flags) begin
          $display("** Error at %0t: rsp.flags = %b, expected %b (tag %0d)",
                   $time, rsp.flags, want.flags, want.tag);
          errors++;
        end
        if (rsp.tag !== want.tag) begin
          $display("** Error at %0t: rsp.tag = %0d, expected %0d", $time, rsp.tag, want.tag);
          errors++;
        end
        if (cycles - issued != `FP_LATENCY) begin
          $display("Response for tag %0d came %0d cycles after its request at %0t",
                   want.tag, cycles - issued, $time);
          errors++;
        end
      end
    end
  end

  initial begin
    fp_op_e op;
    int     center;
    int     spread;
    seed      = 79042;
    errors    = 0;
    checks    = 0;
    next_tag  = '0;
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (5) @(posedge clk);
    #0.5;
    reset = 1'b0;
    // No responses may show up before the first request
    idle_cycles(4);

    // Ties to even, a rounding carry, and exact sums
    issue_request(FP_ADD, 32'h3f800000, 32'h33800000);
    issue_request(FP_ADD, 32'h3f800001, 32'h33800000);
    issue_request(FP_ADD, 32'h4b7fffff, 32'h3f000000);
    issue_request(FP_ADD, 32'h3f800000, 32'h3f800000);
    issue_request(FP_SUB, 32'h3fc00000, 32'h3e800000);
    idle_cycles(2);

    // Cancellation, signed zeros, subnormals as zero
    issue_request(FP_SUB, 32'h40490fdb, 32'h40490fdb);
    issue_request(FP_ADD, 32'h80000000, 32'h80000000);
    issue_request(FP_SUB, 32'h80000000, 32'h00000000);
    issue_request(FP_ADD, 32'h00000001, 32'h3f800000);
    issue_request(FP_ADD, 32'h00400000, 32'h00400000);
    issue_request(FP_ADD, 32'h80400000, 32'h80000000);
    issue_request(FP_SUB, 32'h00800001, 32'h00800000);
    idle_cycles(1);

    // Infinities and NaNs
    issue_request(FP_ADD, 32'h7f800000, 32'h3f800000);
    issue_request(FP_SUB, 32'hff800000, 32'h40000000);
    issue_request(FP_ADD, 32'h7f800000, 32'h7f800000);
    issue_request(FP_SUB, 32'h7f800000, 32'h7f800000);
    issue_request(FP_ADD, 32'h7fc00000, 32'h3f800000);
    issue_request(FP_ADD, 32'hffa00001, 32'h7f800000);

    // Overflow, including a tie that rounds past the largest finite value
    issue_request(FP_ADD, 32'h7f7fffff, 32'h7f7fffff);
    issue_request(FP_SUB, 32'hff7fffff, 32'h7f7fffff);
    issue_request(FP_ADD, 32'h7f7fffff, 32'h73000000);
    idle_cycles(3);

    // Back-to-back burst with distinct tags
    for (int t = 0; t < 8; t++) begin
      issue_request(FP_ADD, 32'h3f800000, 32'h3f800000 + t);
    end
    idle_cycles(3);

    for (int n = 0; n < RANDOM_COUNT; n++) begin
      center = 1 + ($unsigned($random(seed)) % ((1 << `FP_EXP_BITS) - 2));
      spread = (n % 3 == 0) ? 2 : ((n % 3 == 1) ? 40 : (1 << `FP_EXP_BITS));
      op     = ($random(seed) & 1) ? FP_SUB : FP_ADD;
      issue_request(op, random_normal(center, 0), random_normal(center, spread));
      if ($random(seed) & 1) begin
        idle_cycles(1);
      end
    end
    idle_cycles(`FP_LATENCY + 3);

    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      errors += exp_q.size();
    end
    $display("Checked %0d responses, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
fp_pkg.sv
fp_lead_zero.sv
fp_align.sv
fp_adder.sv
fp_add_unit.sv
tb_fp_add_unit.sv

// ==== Bender.yml ====
package:
  name: fp_add_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fp_pkg.sv
      - fp_lead_zero.sv
      - fp_align.sv
      - fp_adder.sv
      - fp_add_unit.sv
      - target: test
        files:
          - tb_fp_add_unit.sv
